//--- fft.f
+incdir+.
fft_pkg.sv
fft_frame_if.sv
fft_twiddle_rom.sv
fft_butterfly.sv
fft_stage.sv
fft.sv
tb_fft.sv

//--- run_sim.sh
#!/bin/sh
# Compile the FFT testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f fft.f --top-module tb_fft -o sim_fft \
  && ./obj_dir/sim_fft | tee /dev/stderr | grep -q "TEST OK" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

exit 0

//--- tb_fft.sv
`timescale 1ns/1ps
`include "fft_settings.svh"

module tb_fft import fft_pkg::*; ();

  localparam int n          = `FFT_N_SAMPLES;
  localparam int latency    = 3;     // One register per stage
  localparam int max_cycles = 2000;  // Well above the length of the whole test sequence

  typedef enum int {K_IMPULSE, K_DC, K_ALT} kind_t;

  logic    clk;
  logic    rst_n;
  sample_t recv_re [n-1:0];
  logic    recv_val;
  logic    recv_rdy;
  sample_t send_re [n-1:0];
  sample_t send_im [n-1:0];
  logic    send_val;
  logic    send_rdy;

  int          cycle = 0;
  int          error_count = 0;
  int          check_count = 0;
  int          in_count = 0;
  int          out_count = 0;
  bit          check_latency = 1'b0;
  logic [15:0] lfsr_state;
  frame_t      exp_q [$];        // Expected real parts, in acceptance order
  int          acc_cycle_q [$];  // Cycle of each acceptance

  fft DUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .recv_re  (recv_re),
    .recv_val (recv_val),
    .recv_rdy (recv_rdy),
    .send_re  (send_re),
    .send_im  (send_im),
    .send_val (send_val),
    .send_rdy (send_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= max_cycles) begin
      $display("timeout: the tests did not finish within %0d cycles", max_cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic check_val(input string what, input logic signed [31:0] got,
                           input logic signed [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // Every frame that leaves the DUT is matched against the oldest pending one
  always @(posedge clk) begin : monitor
    frame_t  exp_re;
    sample_t e;
    int      acc;
    if (rst_n && send_val && send_rdy) begin
      if (exp_q.size() == 0) begin
        error_count++;
        $display("a frame left the DUT at %0t ns while no frame was pending", $time);
      end else begin
        exp_re = exp_q.pop_front();
        acc = acc_cycle_q.pop_front();
        for (int i = 0; i < n; i++) begin
          e = exp_re[i];
          check_val($sformatf("send_re[%0d]", i), send_re[i], e);
          check_val($sformatf("send_im[%0d]", i), send_im[i], 0);
        end
        if (check_latency) begin
          check_val("latency", cycle - acc, latency);
        end
        out_count++;
      end
    end
  end

  // Galois form, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hB400;
    end
    return s >> 1;
  endfunction

  function automatic int rand_bits(input int nbits);
    int v;
    v = 0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = (v << 1) | int'(lfsr_state[0]);
    end
    return v;
  endfunction

  // Signed value in -2^(nbits-1) .. 2^(nbits-1)-1, zero replaced by 1
  function automatic int rand_amp(input int nbits);
    int v;
    v = rand_bits(nbits) - (1 << (nbits - 1));
    if (v == 0) begin
      v = 1;
    end
    return v;
  endfunction

  // Input frame and its spectrum, straight from the DFT of each pattern
  task automatic build_frame(input kind_t kind, input int amp,
                             output frame_t in_re, output frame_t exp_re);
    in_re = '0;
    exp_re = '0;
    case (kind)
      K_IMPULSE: begin
        in_re[0] = sample_t'(amp);
        for (int i = 0; i < n; i++) begin
          exp_re[i] = sample_t'(amp);  // Flat spectrum
        end
      end
      K_DC: begin
        for (int i = 0; i < n; i++) begin
          in_re[i] = sample_t'(amp);
        end
        exp_re[0] = sample_t'(n * amp);
      end
      default: begin
        for (int i = 0; i < n; i++) begin
          in_re[i] = sample_t'((i % 2 == 0) ? amp : -amp);
        end
        exp_re[n/2] = sample_t'(n * amp);  // Nyquist bin
      end
    endcase
  endtask

  task automatic offer_frame(input frame_t in_re);
    for (int i = 0; i < n; i++) begin
      recv_re[i] <= in_re[i];
    end
    recv_val <= 1'b1;
  endtask

  task automatic wait_accept(input frame_t exp_re, output int waited);
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (!recv_rdy);
    exp_q.push_back(exp_re);
    acc_cycle_q.push_back(cycle);
    in_count++;
  endtask

  task automatic send_frame(input kind_t kind, input int amp, output int waited);
    frame_t in_re;
    frame_t exp_re;
    build_frame(kind, amp, in_re, exp_re);
    offer_frame(in_re);
    wait_accept(exp_re, waited);
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);  // Room for a duplicate to show up
  endtask

  // send_rdy stays low here, so recv_rdy can only come from empty stages
  task automatic test_reset();
    @(posedge clk);  // First edge clears the stage registers
    repeat (3) begin
      @(posedge clk);
      check_val("send_val during reset", send_val, 0);
      check_val("recv_rdy during reset", recv_rdy, 1);
    end
    rst_n <= 1'b1;
    repeat (2) begin
      @(posedge clk);
      check_val("send_val after reset", send_val, 0);
      check_val("recv_rdy after reset", recv_rdy, 1);
    end
    send_rdy <= 1'b1;
  endtask

  task automatic test_impulse();
    int waited;
    check_latency = 1'b1;
    send_frame(K_IMPULSE, rand_amp(11), waited);
    recv_val <= 1'b0;
    wait_drain();
  endtask

  task automatic test_dc_alt();
    int waited;
    check_latency = 1'b1;
    send_frame(K_DC, rand_amp(12), waited);
    recv_val <= 1'b0;
    wait_drain();
    send_frame(K_ALT, rand_amp(12), waited);
    recv_val <= 1'b0;
    wait_drain();
  endtask

  task automatic test_streaming();
    int    waited;
    kind_t kind;
    check_latency = 1'b1;
    for (int i = 0; i < 6; i++) begin
      kind = kind_t'(i % 3);
      send_frame(kind, rand_amp(kind == K_IMPULSE ? 11 : 12), waited);
      check_val("cycles to accept a streamed frame", waited, 1);
    end
    recv_val <= 1'b0;
    wait_drain();
  endtask

  task automatic test_backpressure();
    int     waited;
    int     base;
    frame_t in_re;
    frame_t exp_re;
    check_latency = 1'b0;  // Stalled frames stay longer than the latency
    base = out_count;
    send_rdy <= 1'b0;
    for (int i = 0; i < 3; i++) begin
      send_frame(K_DC, rand_amp(12), waited);
      check_val("cycles to accept while filling", waited, 1);
    end
    build_frame(K_ALT, rand_amp(12), in_re, exp_re);
    offer_frame(in_re);
    repeat (4) begin
      @(posedge clk);
      check_val("recv_rdy with all stages full", recv_rdy, 0);
    end
    check_val("frames out while stalled", out_count - base, 0);
    send_rdy <= 1'b1;
    wait_accept(exp_re, waited);
    send_frame(K_IMPULSE, rand_amp(11), waited);
    recv_val <= 1'b0;
    wait_drain();
    check_val("frames out after the stall", out_count - base, 5);
  endtask

  initial begin
    rst_n = 1'b0;
    recv_val = 1'b0;
    send_rdy = 1'b0;
    for (int i = 0; i < n; i++) begin
      recv_re[i] = '0;
    end
    lfsr_state = 16'd86;
    test_reset();
    test_impulse();
    test_dc_alt();
    test_streaming();
    test_backpressure();
    check_val("frames out against frames in", out_count, in_count);
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- fft.sv
`timescale 1ns/1ps
`include "fft_settings.svh"

module fft import fft_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,

  input  sample_t recv_re [`FFT_N_SAMPLES-1:0],
  input  logic    recv_val,
  output logic    recv_rdy,

  output sample_t send_re [`FFT_N_SAMPLES-1:0],
  output sample_t send_im [`FFT_N_SAMPLES-1:0],
  output logic    send_val,
  input  logic    send_rdy
);

  localparam int n = `FFT_N_SAMPLES;

  // Reverse the fft_log2 low bits of an index
  function automatic int bit_rev(input int i);
    int r;
    r = 0;
    for (int b = 0; b < fft_log2; b++) begin
      r = (r << 1) | ((i >> b) & 1);
    end
    return r;
  endfunction

  // Link i feeds stage i, link fft_log2 is the output
  fft_frame_if chain [fft_log2+1] ();

  generate
    for (genvar i = 0; i < n; i++) begin : g_io
      assign chain[0].re[i] = recv_re[bit_rev(i)];
      assign send_re[i]     = chain[fft_log2].re[i];
      assign send_im[i]     = chain[fft_log2].im[i];
    end
  endgenerate

  assign chain[0].im  = '0;                     // Real-only input
  assign chain[0].val = recv_val;
  assign recv_rdy     = chain[0].rdy;

  assign send_val            = chain[fft_log2].val;
  assign chain[fft_log2].rdy = send_rdy;

  generate
    for (genvar s = 0; s < fft_log2; s++) begin : g_stage
      fft_stage #(
        .STAGE (stage_idx_t'(s))
      ) u_stage (
        .clk   (clk),
        .rst_n (rst_n),
        .up    (chain[s]),
        .dn    (chain[s+1])
      );
    end
  endgenerate

  // Source side of the input handshake keeps its offer until taken
  a_recv_hold: assert property (@(posedge clk) disable iff (!rst_n)
    recv_val && !recv_rdy |=> recv_val);

endmodule

//--- fft_stage.sv
`timescale 1ns/1ps
`include "fft_settings.svh"

module fft_stage import fft_pkg::*; #(
  parameter stage_idx_t STAGE = '0
) (
  input logic       clk,
  input logic       rst_n,
  fft_frame_if.snk  up,
  fft_frame_if.src  dn
);

  localparam int n       = `FFT_N_SAMPLES;
  localparam int span    = 1 << STAGE;          // Distance between paired points
  localparam int tw_step = n / (2 * span);      // N / 2^(STAGE+1)

  frame_t bf_re;    // Butterfly results, combinational
  frame_t bf_im;
  frame_t out_re;   // Output register
  frame_t out_im;
  logic   out_val;
  logic   take;

  // Empty register or one that drains this cycle can accept
  assign up.rdy = !out_val || dn.rdy;
  assign take   = up.val && up.rdy;

  generate
    for (genvar b = 0; b < n/2; b++) begin : g_bf
      localparam int grp = b / span;
      localparam int pos = b % span;            // Position inside the group
      localparam int lo  = grp * 2 * span + pos;
      localparam int hi  = lo + span;
      localparam twiddle_idx_t tw = twiddle_idx_t'(pos * tw_step);

      sample_t cos_w;
      sample_t sin_w;

      fft_twiddle_rom u_rom (
        .idx   (tw),
        .cos_w (cos_w),
        .sin_w (sin_w)
      );

      fft_butterfly u_bf (
        .a_re  (up.re[lo]),
        .a_im  (up.im[lo]),
        .b_re  (up.re[hi]),
        .b_im  (up.im[hi]),
        .cos_w (cos_w),
        .sin_w (sin_w),
        .x_re  (bf_re[lo]),
        .x_im  (bf_im[lo]),
        .y_re  (bf_re[hi]),
        .y_im  (bf_im[hi])
      );
    end
  endgenerate

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_val <= 1'b0;
    end else if (take) begin
      out_val <= 1'b1;
    end else if (dn.rdy) begin
      out_val <= 1'b0;                          // Downstream took the frame
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      out_re <= bf_re;
      out_im <= bf_im;
    end
  end

  assign dn.re  = out_re;
  assign dn.im  = out_im;
  assign dn.val = out_val;

  // A stalled frame must not change under the consumer
  a_dn_hold: assert property (@(posedge clk) disable iff (!rst_n)
    dn.val && !dn.rdy |=> dn.val && $stable(dn.re) && $stable(dn.im));

  a_dn_val_known: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(dn.val));

endmodule

//--- fft_butterfly.sv
`timescale 1ns/1ps
`include "fft_settings.svh"

module fft_butterfly import fft_pkg::*; (
  input  sample_t a_re,
  input  sample_t a_im,
  input  sample_t b_re,
  input  sample_t b_im,
  input  sample_t cos_w,
  input  sample_t sin_w,
  output sample_t x_re,
  output sample_t x_im,
  output sample_t y_re,
  output sample_t y_im
);

  localparam int bw = `FFT_BIT_WIDTH;
  localparam int dp = `FFT_DECIMAL_PT;

  // Half an output LSB, added before the shift for round-half-up
  localparam logic signed [2*bw:0] half_lsb = {{(2*bw+1-dp){1'b0}}, 1'b1, {(dp-1){1'b0}}};

  logic signed [2*bw-1:0] p_rc;  // b_re * cos
  logic signed [2*bw-1:0] p_is;  // b_im * sin
  logic signed [2*bw-1:0] p_rs;  // b_re * sin
  logic signed [2*bw-1:0] p_ic;  // b_im * cos

  logic signed [2*bw:0] acc_re;
  logic signed [2*bw:0] acc_im;

  sample_t wb_re;
  sample_t wb_im;

  // Full-width products, no intermediate loss
  assign p_rc = b_re * cos_w;
  assign p_is = b_im * sin_w;
  assign p_rs = b_re * sin_w;
  assign p_ic = b_im * cos_w;

  // w*b, complex multiply
  assign acc_re = p_rc - p_is + half_lsb;
  assign acc_im = p_rs + p_ic + half_lsb;

  // Drop the fraction bits, keep the sample width
  assign wb_re = acc_re[dp +: bw];
  assign wb_im = acc_im[dp +: bw];

  // Sum and difference wrap at the sample width
  assign x_re = a_re + wb_re;
  assign x_im = a_im + wb_im;
  assign y_re = a_re - wb_re;
  assign y_im = a_im - wb_im;

endmodule

//--- fft_twiddle_rom.sv
`timescale 1ns/1ps
`include "fft_settings.svh"

module fft_twiddle_rom import fft_pkg::*; (
  input  twiddle_idx_t idx,
  output sample_t      cos_w,
  output sample_t      sin_w
);

  localparam int  n  = `FFT_N_SAMPLES;
  localparam int  dp = `FFT_DECIMAL_PT;
  localparam real pi = 3.14159265358979323846;

  typedef sample_t [n/2-1:0] tab_t;

  // Table of cos or sin of -2*pi*k/N, rounded half up to the sample grid
  function automatic tab_t build_tab(input bit want_sin);
    tab_t t;
    real  ang;
    real  v;
    real  scale;
    scale = real'(1 << dp);
    for (int k = 0; k < n/2; k++) begin
      ang = -2.0 * pi * real'(k) / real'(n);
      if (want_sin) begin
        v = $sin(ang);
      end else begin
        v = $cos(ang);
      end
      t[k] = sample_t'($rtoi($floor(v * scale + 0.5)));
    end
    return t;
  endfunction

  localparam tab_t cos_tab = build_tab(1'b0);
  localparam tab_t sin_tab = build_tab(1'b1);

  // Plain lookup, zero latency
  assign cos_w = cos_tab[idx];
  assign sin_w = sin_tab[idx];

endmodule

//--- fft_frame_if.sv
`timescale 1ns/1ps
`include "fft_settings.svh"

interface fft_frame_if import fft_pkg::*; ();

  frame_t re;   // Real parts, element i is point i
  frame_t im;   // Imaginary parts
  logic   val;  // Frame on re/im is valid
  logic   rdy;  // Sink can take a frame this cycle

  // Upstream end, owns the data and valid
  modport src (
    output re,
    output im,
    output val,
    input  rdy
  );

  // Downstream end, owns ready
  modport snk (
    input  re,
    input  im,
    input  val,
    output rdy
  );

endinterface

//--- fft_pkg.sv
`include "fft_settings.svh"

package fft_pkg;

  // Number of butterfly stages
  localparam int fft_log2 = $clog2(`FFT_N_SAMPLES);

  // One fixed-point sample, real or imaginary part
  typedef logic signed [`FFT_BIT_WIDTH-1:0] sample_t;

  // Twiddle number 0 .. N/2-1
  typedef logic [fft_log2-2:0] twiddle_idx_t;

  // Stage number 0 .. fft_log2-1
  typedef logic [$clog2(fft_log2)-1:0] stage_idx_t;

  // Whole frame of one component, packed so it can be compared as a word
  typedef sample_t [`FFT_N_SAMPLES-1:0] frame_t;

endpackage

//--- fft_settings.svh
`ifndef FFT_SETTINGS_SVH
`define FFT_SETTINGS_SVH

// Frame size, radix-2 so a power of two
`define FFT_N_SAMPLES 8

// Signed sample width, shared by data and twiddles
`define FFT_BIT_WIDTH 16

// Fraction bits of the fixed-point format
`define FFT_DECIMAL_PT 8

// Format check at a glance:
//   1.0  -> 16'sd256
//  -1.0  -> -16'sd256
//   LSB  -> 1/256

`endif
